/* Makefile */
# Verilator simulation of the N64 glue layer

TOP := tb_n64_glue

sim:
	verilator --binary --timing --assert -f n64_glue.f --top-module $(TOP) -o sim_$(TOP)
	out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* n64_glue.f */
source/glue_pkg.sv
source/download_router.sv
source/pad_lane_mapper.sv
source/snac_pin_router.sv
source/backup_control.sv
source/n64_glue_top.sv
test/clock_gen.sv
test/n64_glue_asserts.sv
test/tb_n64_glue.sv

/* source/backup_control.sv */
// Backup RAM save and load control

module backup_control import glue_pkg::*; (
	input  logic        clk_1x,
	input  logic        rst_n,
	input  logic        n64_active,
	input  logic        gb_active,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic [31:0] img_size,
	input  logic        load_req,
	input  logic        save_req,
	input  logic        osd_status,
	input  logic        autosave_off,
	input  logic        change_pending,
	output logic        bk_load,
	output logic        bk_save,
	output logic        use_img,
	output logic        led_user
);

	logic osd_prev;
	logic n64_prev;
	logic osd_close;
	logic n64_start;
	logic img_usable;

	// Menu opened, good moment to flush the save
	assign osd_close  = osd_status & ~osd_prev;
	assign n64_start  = n64_active & ~n64_prev;
	assign img_usable = img_mounted && (img_size != '0) && !img_readonly;

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			osd_prev <= 1'b0;
			n64_prev <= 1'b0;
			bk_load  <= 1'b0;
			bk_save  <= 1'b0;
			use_img  <= 1'b0;
			led_user <= 1'b0;
		end else begin
			osd_prev <= osd_status;
			n64_prev <= n64_active;
			bk_load  <= load_req | (n64_active & img_mounted);
			bk_save  <= save_req | (osd_close & ~autosave_off);
			led_user <= n64_active | gb_active | change_pending;
			// New cartridge invalidates the image until one is mounted again
			if (n64_start) begin
				use_img <= 1'b0;
			end
			if (img_usable) begin
				use_img <= 1'b1;
			end
		end
	end

endmodule

/* source/download_router.sv */
// Host download router

module download_router import glue_pkg::*; #(
	parameter int N64_BASE = 16777216,
	parameter int GB_BASE  = 8388608
) (
	input  logic                  clk_1x,
	input  logic                  rst_n,
	input  logic                  ioctl_download,
	input  logic [7:0]            ioctl_index,
	input  logic [ADDR_W-1:0]     ioctl_addr,
	input  logic [HALF_W-1:0]     ioctl_dout,
	input  logic                  ioctl_wr,
	input  logic                  ram_wr_ready,
	output logic                  ioctl_wait,
	output logic [PIF_ADDR_W-1:0] pif_addr,
	output logic [WORD_W-1:0]     pif_data,
	output logic                  pif_wren,
	output logic                  ram_wr_valid,
	output logic [ADDR_W-1:0]     ram_wr_addr,
	output logic [WORD_W-1:0]     ram_wr_data,
	output logic                  n64_active,
	output logic                  gb_active
);

	localparam logic [ADDR_W-1:0] N64_OFS = ADDR_W'(N64_BASE);
	localparam logic [ADDR_W-1:0] GB_OFS  = ADDR_W'(GB_BASE);

	logic pif_active;
	logic cart_active;
	logic pif_wr;
	logic cart_wr;

	assign cart_active = n64_active | gb_active;
	assign pif_wr      = pif_active & ioctl_wr;
	assign cart_wr     = cart_active & ioctl_wr;

	// ====================
	// Download type flags
	// ====================
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			pif_active <= 1'b0;
			n64_active <= 1'b0;
			gb_active  <= 1'b0;
		end else begin
			pif_active <= ioctl_download && (ioctl_index[5:0] == DL_PIFROM);
			n64_active <= ioctl_download && (ioctl_index[5:0] == DL_CART_N64);
			gb_active  <= ioctl_download && (ioctl_index[5:0] == DL_CART_GB);
		end
	end

	// ====================
	// Boot ROM path
	// ====================
	// Halfword bytes arrive swapped relative to the ROM word order
	always_ff @(posedge clk_1x) begin
		if (pif_wr) begin
			if (!ioctl_addr[1]) begin
				pif_data[31:24] <= ioctl_dout[7:0];
				pif_data[23:16] <= ioctl_dout[15:8];
				pif_addr        <= {ioctl_index[6], ioctl_addr[10:2]};
			end else begin
				pif_data[15:8] <= ioctl_dout[7:0];
				pif_data[7:0]  <= ioctl_dout[15:8];
			end
		end
	end

	// Strobe only on the upper halfword
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			pif_wren <= 1'b0;
		end else begin
			pif_wren <= pif_wr & ioctl_addr[1];
		end
	end

	// ====================
	// Cartridge path
	// ====================
	always_ff @(posedge clk_1x) begin
		if (cart_wr) begin
			if (!ioctl_addr[1]) begin
				ram_wr_data[15:0] <= ioctl_dout;
				// Each cartridge type has its own memory region
				ram_wr_addr       <= ioctl_addr + (n64_active ? N64_OFS : GB_OFS);
			end else begin
				ram_wr_data[31:16] <= ioctl_dout;
			end
		end
	end

	// Word pending until memory takes it, host stalled meanwhile
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			ram_wr_valid <= 1'b0;
			ioctl_wait   <= 1'b0;
		end else begin
			if (ram_wr_valid && ram_wr_ready) begin
				ram_wr_valid <= 1'b0;
				ioctl_wait   <= 1'b0;
			end
			if (cart_wr && ioctl_addr[1]) begin
				ram_wr_valid <= 1'b1;
				ioctl_wait   <= 1'b1;
			end
			if (!cart_active) begin
				ioctl_wait <= 1'b0;
			end
		end
	end

endmodule

/* source/glue_pkg.sv */
// Glue layer shared definitions

package glue_pkg;

	// ====================
	// Widths
	// ====================
	localparam int ADDR_W     = 27;
	localparam int HALF_W     = 16;
	localparam int WORD_W     = 32;
	localparam int PIF_ADDR_W = 10;
	localparam int JOY_W      = 20;
	localparam int NUM_PADS   = 4;
	localparam int USER_W     = 7;
	localparam int PIN_W      = $clog2(USER_W);

	// Download type codes, low six bits of the host index
	localparam logic [5:0] DL_PIFROM   = 6'd0;
	localparam logic [5:0] DL_CART_N64 = 6'd1;
	localparam logic [5:0] DL_CART_GB  = 6'd2;

	// ====================
	// Joystick word layout
	// ====================
	localparam logic [4:0] JB_RIGHT   = 5'd0;
	localparam logic [4:0] JB_LEFT    = 5'd1;
	localparam logic [4:0] JB_DOWN    = 5'd2;
	localparam logic [4:0] JB_UP      = 5'd3;
	localparam logic [4:0] JB_A       = 5'd4;
	localparam logic [4:0] JB_B       = 5'd5;
	localparam logic [4:0] JB_START   = 5'd6;
	localparam logic [4:0] JB_L       = 5'd7;
	localparam logic [4:0] JB_R       = 5'd8;
	localparam logic [4:0] JB_Z       = 5'd9;
	localparam logic [4:0] JB_C_UP    = 5'd10;
	localparam logic [4:0] JB_C_RIGHT = 5'd11;
	localparam logic [4:0] JB_C_DOWN  = 5'd12;
	localparam logic [4:0] JB_C_LEFT  = 5'd13;

	// Second pad borrows the first pad's C-right as its Z
	typedef enum logic [1:0] {
		DUAL_OFF   = 2'd0,
		DUAL_P1_P2 = 2'd1,
		DUAL_P1_P3 = 2'd2
	} dual_mode_t;

	// ====================
	// SNAC user port map
	// ====================
	// Entry p is the data pin of pad p
	localparam logic [NUM_PADS-1:0][PIN_W-1:0] SNAC_PIN = {3'd4, 3'd5, 3'd0, 3'd1};
	localparam logic [USER_W-1:0] SNAC_IDLE_HIGH_PINS = 7'b100_1100;

endpackage

/* source/n64_glue_top.sv */
// N64 glue layer top

module n64_glue_top import glue_pkg::*; #(
	parameter int N64_BASE = 16777216,
	parameter int GB_BASE  = 8388608
) (
	input  logic                  clk_1x,
	input  logic                  rst_n,
	// Host download
	input  logic                  ioctl_download,
	input  logic [7:0]            ioctl_index,
	input  logic [ADDR_W-1:0]     ioctl_addr,
	input  logic [HALF_W-1:0]     ioctl_dout,
	input  logic                  ioctl_wr,
	output logic                  ioctl_wait,
	// Boot ROM and memory write ports
	output logic [PIF_ADDR_W-1:0] pif_addr,
	output logic [WORD_W-1:0]     pif_data,
	output logic                  pif_wren,
	output logic                  ram_wr_valid,
	output logic [ADDR_W-1:0]     ram_wr_addr,
	output logic [WORD_W-1:0]     ram_wr_data,
	input  logic                  ram_wr_ready,
	// Controllers
	input  logic [JOY_W-1:0]      joy0,
	input  logic [JOY_W-1:0]      joy1,
	input  logic [JOY_W-1:0]      joy2,
	input  logic [JOY_W-1:0]      joy3,
	input  dual_mode_t            dual_mode,
	output logic [NUM_PADS-1:0]   pad_a,
	output logic [NUM_PADS-1:0]   pad_b,
	output logic [NUM_PADS-1:0]   pad_z,
	output logic [NUM_PADS-1:0]   pad_start,
	output logic [NUM_PADS-1:0]   pad_l,
	output logic [NUM_PADS-1:0]   pad_r,
	output logic [NUM_PADS-1:0]   dpad_up,
	output logic [NUM_PADS-1:0]   dpad_down,
	output logic [NUM_PADS-1:0]   dpad_left,
	output logic [NUM_PADS-1:0]   dpad_right,
	output logic [NUM_PADS-1:0]   c_up,
	output logic [NUM_PADS-1:0]   c_down,
	output logic [NUM_PADS-1:0]   c_left,
	output logic [NUM_PADS-1:0]   c_right,
	// Serial adapter
	input  logic                  snac_en,
	input  logic [1:0]            pad_index,
	input  logic                  snac_tx,
	output logic                  snac_rx,
	input  logic [USER_W-1:0]     user_in,
	output logic [USER_W-1:0]     user_out,
	// Backup RAM
	input  logic                  img_mounted,
	input  logic                  img_readonly,
	input  logic [31:0]           img_size,
	input  logic                  load_req,
	input  logic                  save_req,
	input  logic                  osd_status,
	input  logic                  autosave_off,
	input  logic                  change_pending,
	output logic                  bk_load,
	output logic                  bk_save,
	output logic                  use_img,
	output logic                  led_user
);

	// Cartridge download flags shared with backup control
	logic n64_active;
	logic gb_active;

	download_router #(
		.N64_BASE (N64_BASE),
		.GB_BASE  (GB_BASE)
	) u_download_router (
		.clk_1x, .rst_n,
		.ioctl_download, .ioctl_index, .ioctl_addr, .ioctl_dout, .ioctl_wr,
		.ram_wr_ready, .ioctl_wait,
		.pif_addr, .pif_data, .pif_wren,
		.ram_wr_valid, .ram_wr_addr, .ram_wr_data,
		.n64_active, .gb_active
	);

	pad_lane_mapper u_pad_lane_mapper (
		.clk_1x, .rst_n,
		.joy0, .joy1, .joy2, .joy3, .dual_mode,
		.pad_a, .pad_b, .pad_z, .pad_start, .pad_l, .pad_r,
		.dpad_up, .dpad_down, .dpad_left, .dpad_right,
		.c_up, .c_down, .c_left, .c_right
	);

	snac_pin_router u_snac_pin_router (
		.clk_1x, .rst_n,
		.snac_en, .pad_index, .snac_tx, .user_in,
		.user_out, .snac_rx
	);

	backup_control u_backup_control (
		.clk_1x, .rst_n,
		.n64_active, .gb_active,
		.img_mounted, .img_readonly, .img_size,
		.load_req, .save_req, .osd_status, .autosave_off, .change_pending,
		.bk_load, .bk_save, .use_img, .led_user
	);

endmodule

/* source/pad_lane_mapper.sv */
// Joystick to button lane mapping

module pad_lane_mapper import glue_pkg::*; (
	input  logic                clk_1x,
	input  logic                rst_n,
	input  logic [JOY_W-1:0]    joy0,
	input  logic [JOY_W-1:0]    joy1,
	input  logic [JOY_W-1:0]    joy2,
	input  logic [JOY_W-1:0]    joy3,
	input  dual_mode_t          dual_mode,
	output logic [NUM_PADS-1:0] pad_a,
	output logic [NUM_PADS-1:0] pad_b,
	output logic [NUM_PADS-1:0] pad_z,
	output logic [NUM_PADS-1:0] pad_start,
	output logic [NUM_PADS-1:0] pad_l,
	output logic [NUM_PADS-1:0] pad_r,
	output logic [NUM_PADS-1:0] dpad_up,
	output logic [NUM_PADS-1:0] dpad_down,
	output logic [NUM_PADS-1:0] dpad_left,
	output logic [NUM_PADS-1:0] dpad_right,
	output logic [NUM_PADS-1:0] c_up,
	output logic [NUM_PADS-1:0] c_down,
	output logic [NUM_PADS-1:0] c_left,
	output logic [NUM_PADS-1:0] c_right
);

	logic [NUM_PADS-1:0][JOY_W-1:0] joy_all;
	logic [NUM_PADS-1:0]            z_lanes;

	// One bit position taken from every pad, lane p from pad p
	function automatic logic [NUM_PADS-1:0] gather(
		input logic [NUM_PADS-1:0][JOY_W-1:0] joys,
		input logic [4:0]                     pos
	);
		logic [NUM_PADS-1:0] lanes;
		for (int p = 0; p < NUM_PADS; p++) begin
			lanes[p] = joys[p][pos];
		end
		return lanes;
	endfunction

	assign joy_all = {joy3, joy2, joy1, joy0};

	// Dual controller: C-right of a driving pad stands in as Z of a follower
	always_comb begin
		z_lanes = gather(joy_all, JB_Z);
		case (dual_mode)
			DUAL_P1_P2: begin
				z_lanes[1] = joy0[JB_C_RIGHT];
				z_lanes[3] = joy2[JB_C_RIGHT];
			end
			DUAL_P1_P3: begin
				z_lanes[2] = joy0[JB_C_RIGHT];
				z_lanes[3] = joy1[JB_C_RIGHT];
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			pad_a      <= '0;
			pad_b      <= '0;
			pad_z      <= '0;
			pad_start  <= '0;
			pad_l      <= '0;
			pad_r      <= '0;
			dpad_up    <= '0;
			dpad_down  <= '0;
			dpad_left  <= '0;
			dpad_right <= '0;
			c_up       <= '0;
			c_down     <= '0;
			c_left     <= '0;
			c_right    <= '0;
		end else begin
			pad_a      <= gather(joy_all, JB_A);
			pad_b      <= gather(joy_all, JB_B);
			pad_z      <= z_lanes;
			pad_start  <= gather(joy_all, JB_START);
			pad_l      <= gather(joy_all, JB_L);
			pad_r      <= gather(joy_all, JB_R);
			dpad_up    <= gather(joy_all, JB_UP);
			dpad_down  <= gather(joy_all, JB_DOWN);
			dpad_left  <= gather(joy_all, JB_LEFT);
			dpad_right <= gather(joy_all, JB_RIGHT);
			c_up       <= gather(joy_all, JB_C_UP);
			c_down     <= gather(joy_all, JB_C_DOWN);
			c_left     <= gather(joy_all, JB_C_LEFT);
			c_right    <= gather(joy_all, JB_C_RIGHT);
		end
	end

endmodule

/* source/snac_pin_router.sv */
// SNAC user port steering

module snac_pin_router import glue_pkg::*; (
	input  logic              clk_1x,
	input  logic              rst_n,
	input  logic              snac_en,
	input  logic [1:0]        pad_index,
	input  logic              snac_tx,
	input  logic [USER_W-1:0] user_in,
	output logic [USER_W-1:0] user_out,
	output logic              snac_rx
);

	logic [PIN_W-1:0]  sel_pin;
	logic [USER_W-1:0] user_next;

	assign sel_pin = SNAC_PIN[pad_index];

	// Other pad pins keep their last level
	always_comb begin
		user_next          = user_out | SNAC_IDLE_HIGH_PINS;
		user_next[sel_pin] = snac_tx;
	end

	// ====================
	// Port registers
	// ====================
	// Open drain port, all ones lets the pins be read
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			user_out <= '1;
			snac_rx  <= 1'b1;
		end else if (snac_en) begin
			user_out <= user_next;
			snac_rx  <= user_in[sel_pin];
		end else begin
			user_out <= '1;
		end
	end

endmodule

/* test/clock_gen.sv */
// Testbench clock source

module clock_gen (
	output logic clk_1x
);

	initial begin
		clk_1x = 1'b0;
	end

	// Period of 4
	always #2 clk_1x = ~clk_1x;

endmodule

/* test/glue_patterns.txt */
// Columns: code p0 p1 p2 p3 p4, all hex, one record per line
// 1 boot ROM: index addr {hi,lo} pif_data pif_addr; 2 cartridge: index addr {hi,lo} data addr
1 40 7F8 ABCD1234 3412CDAB 3FE
1 00 010 77885566 66558877 004
2 01 100 BEEF1357 BEEF1357 1000100
2 02 204 0123CAFE 0123CAFE 0800204
// 4 pads: joy0 joy1 joy2 joy3 {mode[17:16], z, c_right, a, up}
4 210 800 208 3FFF 0DA9C
4 800 200 800 200 1A500
4 A00 800 200 200 2D300
// 5 SNAC: en pad_index tx user_in {user_out[14:8], rx[0]}
5 1 0 0 02 7D01
5 1 1 0 01 7C01
5 1 2 1 00 7C00
5 1 3 0 10 6C01
5 0 0 0 00 7F01
// 6 backup: inputs img_size {download,index} cycles {load,save,use_img,led}
// inputs bits: 0 mounted, 1 readonly, 2 load, 3 save, 4 osd, 5 autosave_off, 6 change
6 00 0 000 2 0
6 10 0 000 1 4
6 10 0 000 1 0
6 00 0 000 1 0
6 30 0 000 1 0
6 00 0 000 1 0
6 01 2000 000 1 2
6 00 2000 101 2 1
6 00 2000 101 1 1
6 03 2000 101 1 9
6 00 2000 000 2 0
6 00 0 102 2 1
6 00 0 000 2 0
6 40 0 000 1 1
6 08 0 000 1 4
6 04 0 000 1 8
0 0 0 0 0 0

/* test/n64_glue_asserts.sv */
// Download router protocol checks

module n64_glue_asserts import glue_pkg::*; (
	input logic              clk_1x,
	input logic              rst_n,
	input logic              ioctl_wait,
	input logic              ram_wr_valid,
	input logic              ram_wr_ready,
	input logic [ADDR_W-1:0] ram_wr_addr,
	input logic [WORD_W-1:0] ram_wr_data,
	input logic              pif_wren
);

	// Host must be held while a word is pending
	wait_with_valid: assert property (@(posedge clk_1x) disable iff (!rst_n)
		ram_wr_valid |-> ioctl_wait)
		else $error("ioctl_wait low while ram_wr_valid high");

	// ====================
	// Memory handshake
	// ====================
	stable_while_stalled: assert property (@(posedge clk_1x) disable iff (!rst_n)
		ram_wr_valid && !ram_wr_ready |=> $stable(ram_wr_addr) && $stable(ram_wr_data))
		else $error("ram_wr_addr or ram_wr_data changed during a stall");

	single_pif_strobe: assert property (@(posedge clk_1x) disable iff (!rst_n)
		pif_wren |=> !pif_wren)
		else $error("pif_wren high for two cycles");

endmodule

bind download_router n64_glue_asserts u_router_asserts (
	.clk_1x, .rst_n, .ioctl_wait, .ram_wr_valid, .ram_wr_ready,
	.ram_wr_addr, .ram_wr_data, .pif_wren
);

/* test/tb_n64_glue.sv */
// N64 glue layer testbench

module tb_n64_glue import glue_pkg::*; ();

	localparam int MAX_REC = 64;
	localparam int REC_W   = 6;

	logic clk_1x;
	logic rst_n;
	logic ioctl_download, ioctl_wr, ioctl_wait, pif_wren;
	logic [7:0] ioctl_index;
	logic [ADDR_W-1:0] ioctl_addr, ram_wr_addr;
	logic [HALF_W-1:0] ioctl_dout;
	logic [PIF_ADDR_W-1:0] pif_addr;
	logic [WORD_W-1:0] pif_data, ram_wr_data;
	logic ram_wr_valid, ram_wr_ready;
	logic [JOY_W-1:0] joy0, joy1, joy2, joy3;
	dual_mode_t dual_mode;
	logic [NUM_PADS-1:0] pad_a, pad_b, pad_z, pad_start, pad_l, pad_r;
	logic [NUM_PADS-1:0] dpad_up, dpad_down, dpad_left, dpad_right;
	logic [NUM_PADS-1:0] c_up, c_down, c_left, c_right;
	logic snac_en, snac_tx, snac_rx;
	logic [1:0] pad_index;
	logic [USER_W-1:0] user_in, user_out;
	logic img_mounted, img_readonly, load_req, save_req;
	logic osd_status, autosave_off, change_pending;
	logic [31:0] img_size;
	logic bk_load, bk_save, use_img, led_user;

	logic [31:0] pat [0:MAX_REC*REC_W-1];
	int errors;
	int checks;
	int pif_strobes;
	int words_taken;
	int n_rec;
	longint wd_time;
	logic wd_armed = 1'b0;

	clock_gen u_clock_gen (.clk_1x);

	n64_glue_top uut (.*);

	// Events counted where the DUT itself samples them
	always @(posedge clk_1x) begin
		if (pif_wren) pif_strobes++;
		if (ram_wr_valid && ram_wr_ready) words_taken++;
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// Lane p of a button is bit pos of pad p's joystick word
	function automatic logic [NUM_PADS-1:0] joy_lanes(input logic [4:0] pos);
		return {joy3[pos], joy2[pos], joy1[pos], joy0[pos]};
	endfunction

	// ====================
	// Behaviors
	// ====================
	task automatic write_pair(input logic [31:0] idx, input logic [31:0] addr,
		input logic [31:0] dout);
		ioctl_download = 1'b1;
		ioctl_index    = idx[7:0];
		@(negedge clk_1x);
		ioctl_wr   = 1'b1;
		ioctl_addr = addr[ADDR_W-1:0];
		ioctl_dout = dout[15:0];
		@(negedge clk_1x);
		ioctl_addr = addr[ADDR_W-1:0] | ADDR_W'(2);
		ioctl_dout = dout[31:16];
		@(negedge clk_1x);
		ioctl_wr = 1'b0;
	endtask

	task automatic boot_write(input logic [31:0] p0, p1, p2, p3, p4);
		pif_strobes = 0;
		write_pair(p0, p1, p2);
		repeat (3) @(negedge clk_1x);
		check("pif_wren count", 32'(pif_strobes), 32'd1);
		check("pif_data", pif_data, p3);
		check("pif_addr", 32'(pif_addr), p4);
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_1x);
	endtask

	task automatic cart_write(input logic [31:0] p0, p1, p2, p3, p4);
		int stall;
		int waited;
		words_taken = 0;
		write_pair(p0, p1, p2);
		waited = 0;
		while (!ram_wr_valid && waited < 16) begin
			@(negedge clk_1x);
			waited++;
		end
		if (!ram_wr_valid) begin
			errors++;
			$display("Cartridge word never became valid, time %0t", $time);
		end
		check("ioctl_wait", 32'(ioctl_wait), 32'd1);
		check("ram_wr_addr", 32'(ram_wr_addr), p4);
		check("ram_wr_data", ram_wr_data, p3);
		stall = int'($urandom % 8);
		repeat (stall) begin
			@(negedge clk_1x);
			check("ram_wr_valid", 32'(ram_wr_valid), 32'd1);
			check("ioctl_wait", 32'(ioctl_wait), 32'd1);
		end
		ram_wr_ready = 1'b1;
		@(negedge clk_1x);
		ram_wr_ready = 1'b0;
		check("ram_wr_valid", 32'(ram_wr_valid), 32'd0);
		check("ioctl_wait", 32'(ioctl_wait), 32'd0);
		repeat (2) @(negedge clk_1x);
		check("accepted words", 32'(words_taken), 32'd1);
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_1x);
	endtask

	task automatic lane_map(input logic [31:0] p0, p1, p2, p3, p4);
		joy0      = p0[JOY_W-1:0];
		joy1      = p1[JOY_W-1:0];
		joy2      = p2[JOY_W-1:0];
		joy3      = p3[JOY_W-1:0];
		dual_mode = dual_mode_t'(p4[17:16]);
		@(negedge clk_1x);
		check("pad_z", 32'(pad_z), 32'(p4[15:12]));
		check("c_right", 32'(c_right), 32'(p4[11:8]));
		check("pad_a", 32'(pad_a), 32'(p4[7:4]));
		check("dpad_up", 32'(dpad_up), 32'(p4[3:0]));
		// Buttons without a remap follow the plain lane rule
		check("pad_b", 32'(pad_b), 32'(joy_lanes(JB_B)));
		check("pad_start", 32'(pad_start), 32'(joy_lanes(JB_START)));
		check("pad_l", 32'(pad_l), 32'(joy_lanes(JB_L)));
		check("pad_r", 32'(pad_r), 32'(joy_lanes(JB_R)));
		check("dpad_down", 32'(dpad_down), 32'(joy_lanes(JB_DOWN)));
		check("dpad_left", 32'(dpad_left), 32'(joy_lanes(JB_LEFT)));
		check("dpad_right", 32'(dpad_right), 32'(joy_lanes(JB_RIGHT)));
		check("c_up", 32'(c_up), 32'(joy_lanes(JB_C_UP)));
		check("c_down", 32'(c_down), 32'(joy_lanes(JB_C_DOWN)));
		check("c_left", 32'(c_left), 32'(joy_lanes(JB_C_LEFT)));
	endtask

	task automatic snac_route(input logic [31:0] p0, p1, p2, p3, p4);
		snac_en   = p0[0];
		pad_index = p1[1:0];
		snac_tx   = p2[0];
		user_in   = p3[USER_W-1:0];
		@(negedge clk_1x);
		check("user_out", 32'(user_out), 32'(p4[14:8]));
		check("snac_rx", 32'(snac_rx), 32'(p4[0]));
	endtask

	task automatic backup_step(input logic [31:0] p0, p1, p2, p3, p4);
		img_mounted    = p0[0];
		img_readonly   = p0[1];
		load_req       = p0[2];
		save_req       = p0[3];
		osd_status     = p0[4];
		autosave_off   = p0[5];
		change_pending = p0[6];
		img_size       = p1;
		ioctl_download = p2[8];
		ioctl_index    = p2[7:0];
		repeat (p3) @(negedge clk_1x);
		check("bk_load", 32'(bk_load), 32'(p4[3]));
		check("bk_save", 32'(bk_save), 32'(p4[2]));
		check("use_img", 32'(use_img), 32'(p4[1]));
		check("led_user", 32'(led_user), 32'(p4[0]));
	endtask

	// ====================
	// Run control
	// ====================
	initial begin
		wait (wd_armed);
		#(wd_time);
		$display("Watchdog expired at %0t before the tests finished", $time);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		int base;
		void'($urandom(97));
		rst_n = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ioctl_wr = 1'b0;
		ram_wr_ready = 1'b0;
		joy0 = '0;
		joy1 = '0;
		joy2 = '0;
		joy3 = '0;
		dual_mode = DUAL_OFF;
		snac_en = 1'b0;
		pad_index = '0;
		snac_tx = 1'b0;
		user_in = '0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size = '0;
		load_req = 1'b0;
		save_req = 1'b0;
		osd_status = 1'b0;
		autosave_off = 1'b0;
		change_pending = 1'b0;
		errors = 0;
		checks = 0;
		foreach (pat[k]) pat[k] = '0;
		$readmemh("test/glue_patterns.txt", pat);
		n_rec = 0;
		while (n_rec < MAX_REC && pat[n_rec*REC_W] != 0) n_rec++;
		wd_time = longint'(n_rec + 1) * 40 * 4;
		wd_armed = 1'b1;
		if (n_rec == 0) begin
			errors++;
			$display("No records found in the pattern file");
		end
		repeat (16) @(negedge clk_1x);
		rst_n = 1'b1;
		check("user_out after reset", 32'(user_out), 32'h7f);
		check("use_img after reset", 32'(use_img), 32'd0);
		for (int i = 0; i < n_rec; i++) begin
			base = i * REC_W;
			case (pat[base])
				1: boot_write(pat[base+1], pat[base+2], pat[base+3], pat[base+4], pat[base+5]);
				2: cart_write(pat[base+1], pat[base+2], pat[base+3], pat[base+4], pat[base+5]);
				4: lane_map(pat[base+1], pat[base+2], pat[base+3], pat[base+4], pat[base+5]);
				5: snac_route(pat[base+1], pat[base+2], pat[base+3], pat[base+4], pat[base+5]);
				6: backup_step(pat[base+1], pat[base+2], pat[base+3], pat[base+4], pat[base+5]);
				default: begin
					errors++;
					$display("Record %0d has an unknown behavior code %h", i, pat[base]);
				end
			endcase
		end
		$display("Records: %0d, checks: %0d, errors: %0d", n_rec, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
